/* Makefile */
TOP = emesh_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: build
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "No verdict in $(LOG)"; exit 1; }

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
rtl/emesh_pkg.sv
rtl/emesh_fifo.sv
rtl/emesh_memory.sv
rtl/emesh_top.sv
dv/emesh_tb.sv

/* dv/emesh_cases.txt */
// op addr data srcaddr ctrlmode datamode expected_read_data
// op: 0 read, 1 write, 2 hold wait_in, 3 release wait_in, 4 check wait_out, 5 drain, f end
// Write then read back
1 00000000 11111111 00000000 00 2 00000000
0 00000000 00000000 a0000000 01 2 11111111
1 00000004 deadbeef 00000000 03 1 00000000
0 00000004 00000000 a0000004 1f 3 deadbeef
// Rewrite and immediate reread
1 00000004 cafef00d 00000000 00 2 00000000
0 00000004 00000000 b0000004 05 0 cafef00d
// Never written, reads zero
0 00000200 00000000 c0000000 0a 2 00000000
0 000003fc 00000000 c0000004 11 1 00000000
// Byte bits and bits above 9 drop out of the word index
1 00000013 12345678 00000000 00 2 00000000
0 00000010 00000000 d0000000 02 2 12345678
0 80000410 00000000 d0000004 1c 2 12345678
// Back-to-back mix under random wait_in
1 00000100 a5a5a5a5 00000000 00 2 00000000
1 00000104 5a5a5a5a 00000000 00 2 00000000
0 00000100 00000000 e0000000 07 2 a5a5a5a5
0 00000104 00000000 e0000004 08 3 5a5a5a5a
0 00000108 00000000 e0000008 09 0 00000000
5 00000000 00000000 00000000 00 0 00000000
// Six reads with wait_in held high
2 00000000 00000000 00000000 00 0 00000000
0 00000000 00000000 f0000000 01 2 11111111
0 00000004 00000000 f0000004 02 2 cafef00d
0 00000010 00000000 f0000008 03 2 12345678
0 00000100 00000000 f000000c 04 2 a5a5a5a5
0 00000104 00000000 f0000010 05 2 5a5a5a5a
4 00000000 00000000 00000000 00 0 00000000
0 00000108 00000000 f0000014 06 2 00000000
4 00000000 00000000 00000000 00 0 00000001
3 00000000 00000000 00000000 00 0 00000000
5 00000000 00000000 00000000 00 0 00000000
// Write behind a full egress queue, four reads fit after it
2 00000000 00000000 00000000 00 0 00000000
0 00000000 00000000 90000000 0b 1 11111111
0 00000004 00000000 90000004 0c 1 cafef00d
1 00000300 77665544 00000000 00 2 00000000
0 00000300 00000000 90000008 0d 2 77665544
0 00000200 00000000 9000000c 0e 2 00000000
0 00000010 00000000 90000010 0f 2 12345678
4 00000000 00000000 00000000 00 0 00000000
0 00000104 00000000 90000014 10 2 5a5a5a5a
4 00000000 00000000 00000000 00 0 00000001
3 00000000 00000000 00000000 00 0 00000000
5 00000000 00000000 00000000 00 0 00000000
f 00000000 00000000 00000000 00 0 00000000

/* dv/emesh_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module emesh_tb;

   // ####################
   // DUT hookup
   // ####################
   logic                     clk       = 1'b0;
   logic                     nreset    = 1'b0;
   logic                     access_in = 1'b0;
   emesh_pkg::emesh_packet_t packet_in = '0;
   logic                     wait_in   = 1'b0;
   logic                     wait_out;
   logic                     access_out;
   emesh_pkg::emesh_packet_t packet_out;

   logic [31:0]              case_mem [0:447];   // Up to 64 cases of 7 words
   emesh_pkg::emesh_packet_t exp_q [$];          // Reads awaiting a response
   emesh_pkg::emesh_packet_t held_pkt = '0;      // Head seen under wait_in
   logic                     held_valid = 1'b0;  // Last edge was a stall
   logic                     hold_wait  = 1'b0;  // Force wait_in high
   logic                     loaded     = 1'b0;  // Case file counted
   int                       seed       = 32'h3f20;
   int                       num_cases  = 0;
   int                       rsp_count  = 0;

   emesh_top emesh_top_i (
      .clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in)
   );

   always #5 clk = ~clk;                          // 10 ns period

   // Back-pressure from the receiver, random unless held
   always @(negedge clk) begin
      if (hold_wait) begin
         wait_in = 1'b1;
      end else begin
         wait_in = ($random(seed) & 32'h1) != 0;
      end
   end

   // ####################
   // Helpers
   // ####################
   task automatic check_value(input logic [emesh_pkg::PW-1:0] got,
                              input logic [emesh_pkg::PW-1:0] exp_val,
                              input string what);
      if (got !== exp_val) begin
         $display("error at %0t ns: %s, got %h expected %h", $time, what, got, exp_val);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Single flag padded to packet width
   function automatic logic [emesh_pkg::PW-1:0] flag_word(input logic b);
      flag_word    = '0;
      flag_word[0] = b;
   endfunction

   // One column of one case line
   function automatic logic [31:0] field(input int idx, input int col);
      return case_mem[idx*7 + col];
   endfunction

   // Offer a packet once the ingress side has room
   task automatic send_request(input emesh_pkg::emesh_packet_t pkt);
      while (wait_out) begin
         @(negedge clk);                          // Ingress full, hold off
      end
      access_in = 1'b1;
      packet_in = pkt;
      @(posedge clk);                             // Taken at this edge
   endtask

   task automatic run_case(input int idx);
      logic [31:0]              op;
      logic [31:0]              exp_word;
      emesh_pkg::emesh_packet_t req;
      emesh_pkg::emesh_packet_t rsp;
      op           = field(idx, 0);
      exp_word     = field(idx, 6);
      req          = '0;
      req.dstaddr  = field(idx, 1);
      req.data     = field(idx, 2);
      req.srcaddr  = field(idx, 3);
      req.ctrlmode = 5'(field(idx, 4));          // 5-bit field
      req.datamode = 2'(field(idx, 5));
      req.write    = (op == 32'h1);
      case (op)
         32'h0: begin
            rsp          = '0;                    // Expected read response
            rsp.srcaddr  = req.dstaddr;
            rsp.dstaddr  = req.srcaddr;
            rsp.data     = exp_word;
            rsp.ctrlmode = req.ctrlmode;
            rsp.datamode = req.datamode;
            rsp.write    = 1'b0;
            exp_q.push_back(rsp);
            send_request(req);
         end
         32'h1: send_request(req);
         32'h2: begin
            @(posedge clk);
            hold_wait = 1'b1;                     // Takes effect next fall
         end
         32'h3: begin
            @(posedge clk);
            hold_wait = 1'b0;
         end
         32'h4: check_value(flag_word(wait_out), flag_word(exp_word[0]), "wait_out");
         32'h5: begin
            while (exp_q.size() != 0) begin
               @(negedge clk);                    // Watchdog bounds this
            end
            check_value(flag_word(wait_out), flag_word(exp_word[0]), "wait_out after drain");
         end
         default: begin
            $display("case %0d has an unknown operation code %h", idx, op);
            $display("TESTBENCH FAILED");
            $fatal(1, "bad case file");
         end
      endcase
   endtask

   // ####################
   // Response monitor
   // ####################
   always @(posedge clk) begin
      if (nreset) begin
         if (held_valid) begin
            check_value(flag_word(access_out), flag_word(1'b1), "access_out under wait_in");
            check_value(packet_out, held_pkt, "packet_out under wait_in");
         end
         held_valid = access_out && wait_in;
         held_pkt   = packet_out;
         if (access_out && !wait_in) begin
            if (exp_q.size() != 0) begin
               check_value(packet_out, exp_q.pop_front(), "read response");
               rsp_count++;
            end else begin
               $display("a read response arrived at %0t ns with no read outstanding", $time);
               $display("TESTBENCH FAILED");
               $fatal(1, "unexpected response");
            end
         end
      end
   end

   // Limit from the case count plus the 8 reset cycles
   initial begin
      wait (loaded);
      repeat (num_cases * 50 + 8) @(posedge clk);
      $display("timeout: %0d read responses are missing", exp_q.size());
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

   // ####################
   // Stimulus
   // ####################
   initial begin
      $readmemh("dv/emesh_cases.txt", case_mem);
      while (num_cases < 64 && field(num_cases, 0) !== 32'hf) begin
         num_cases++;                             // Scan to end marker
      end
      if (num_cases == 0 || num_cases == 64) begin
         $display("case file is missing, empty or has no end marker");
         $display("TESTBENCH FAILED");
         $fatal(1, "no cases");
      end
      loaded = 1'b1;
      repeat (8) @(posedge clk);                  // Reset held 8 cycles
      @(negedge clk);
      nreset = 1'b1;
      for (int i = 0; i < num_cases; i++) begin
         @(negedge clk);
         access_in = 1'b0;                        // Idle unless sending
         run_case(i);
      end
      @(negedge clk);
      access_in = 1'b0;
      while (exp_q.size() != 0) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);                  // Catch stray responses
      $display("%0d cases run, %0d read responses checked", num_cases, rsp_count);
      if (exp_q.size() == 0 && !access_out) begin
         $display("TESTBENCH PASSED");
         $finish;
      end else begin
         $display("responses were still pending at the end of the run");
         $display("TESTBENCH FAILED");
         $fatal(1, "pending responses");
      end
   end

endmodule

`default_nettype wire

/* rtl/emesh_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module emesh_fifo #(
   parameter int DEPTH = 4                      // Entries
) (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       push,
   input  wire emesh_pkg::emesh_packet_t push_data,
   input  wire                       pop,
   output emesh_pkg::emesh_packet_t  pop_data,
   output logic                      empty,
   output logic                      full
);

   localparam int PTRW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNTW = $clog2(DEPTH + 1);

   // ####################
   // Storage
   // ####################
   logic [emesh_pkg::PW-1:0] buf_q [DEPTH];     // Packet slots, no reset
   logic [PTRW-1:0]          wr_ptr_q;          // Next slot to fill
   logic [PTRW-1:0]          rd_ptr_q;          // Current head slot
   logic [CNTW-1:0]          count_q;           // Occupancy

   always_ff @(posedge clk) begin
      if (push) begin
         buf_q[wr_ptr_q] <= push_data;          // Lands at wr slot
      end
   end

   // ####################
   // Pointers and count
   // ####################
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTRW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // Wrap
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTRW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1; // Wrap
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1; // Fill only
            2'b01:   count_q <= count_q - 1'b1; // Drain only
            default: count_q <= count_q;        // Both or neither
         endcase
      end
   end

   // Show-ahead head, flags off the registered count
   assign pop_data = buf_q[rd_ptr_q];
   assign empty    = (count_q == '0);
   assign full     = (count_q == CNTW'(DEPTH));

   // ####################
   // Checks
   // ####################
   // Producer must respect full
   a_no_overflow : assert property (
      @(posedge clk) disable iff (!nreset)
      !(push && full && !pop)
   ) else $error("emesh_fifo overflow");

   // Consumer must respect empty
   a_no_underflow : assert property (
      @(posedge clk) disable iff (!nreset)
      !(pop && empty)
   ) else $error("emesh_fifo underflow");

endmodule

`default_nettype wire

/* rtl/emesh_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module emesh_memory (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire emesh_pkg::emesh_packet_t req,   // Ingress head
   input  wire                       req_empty,
   input  wire                       rsp_full,
   output logic                      req_pop,
   output logic                      rsp_push,
   output emesh_pkg::emesh_packet_t  rsp        // Read response
);

   // ####################
   // Word array
   // ####################
   logic [emesh_pkg::DW-1:0]     mem_q [emesh_pkg::MEM_WORDS];
   logic [emesh_pkg::MEM_AW-1:0] word_idx;      // Word select from dstaddr
   logic [emesh_pkg::DW-1:0]     rd_word;       // Current stored word
   logic                         req_write;     // Write retires this cycle

   assign word_idx = req.dstaddr[emesh_pkg::MEM_AW+1:2]; // Byte addr to word
   assign rd_word  = mem_q[word_idx];

   // ####################
   // Issue decision
   // ####################
   // Head leaves when it is a write or the egress queue has room
   assign req_pop   = !req_empty && (req.write || !rsp_full);
   assign req_write = req_pop && req.write;
   assign rsp_push  = req_pop && !req.write;    // Reads only

   // Array cleared on reset, written at the edge
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < emesh_pkg::MEM_WORDS; i++) begin
            mem_q[i] <= '0;
         end
      end else if (req_write) begin
         mem_q[word_idx] <= req.data;           // Full word store
      end
   end

   // ####################
   // Response build
   // ####################
   always_comb begin
      rsp          = '0;
      rsp.srcaddr  = req.dstaddr;               // Swap header
      rsp.dstaddr  = req.srcaddr;               // Back to requester
      rsp.data     = rd_word;
      rsp.ctrlmode = req.ctrlmode;              // Echo
      rsp.datamode = req.datamode;              // Echo, width ignored
      rsp.write    = 1'b0;                      // Read response marker
   end

   // ####################
   // Checks
   // ####################
   // A stalled head stays put in the ingress queue
   a_head_stable : assert property (
      @(posedge clk) disable iff (!nreset)
      (!req_empty && !req_pop) |=> (!req_empty && req == $past(req))
   ) else $error("emesh_memory head changed while stalled");

endmodule

`default_nettype wire

/* rtl/emesh_pkg.sv */
`default_nettype none

package emesh_pkg;

   // ####################
   // Mesh field widths
   // ####################
   localparam int PW = 104;                     // Full packet width
   localparam int AW = 32;                      // Address width
   localparam int DW = 32;                      // Data width

   // ####################
   // Endpoint sizing
   // ####################
   localparam int MEM_AW    = 8;                // Word index bits
   localparam int MEM_WORDS = 1 << MEM_AW;      // 256 words
   localparam int IN_DEPTH  = 4;                // Ingress queue entries
   localparam int OUT_DEPTH = 2;                // Egress queue entries

   // Mesh packet layout, MSB first
   typedef struct packed {
      logic [AW-1:0] srcaddr;                   // Return address for reads
      logic [DW-1:0] data;                      // Write data or read data
      logic [AW-1:0] dstaddr;                   // Target address
      logic [4:0]    ctrlmode;                  // Passed through untouched
      logic [1:0]    datamode;                  // Width code, only echoed
      logic          write;                     // 1 for write, 0 for read
   } emesh_packet_t;

endpackage

`default_nettype wire

/* rtl/emesh_top.sv */
`timescale 1ns/1ns
`default_nettype none

module emesh_top (
   input  wire                       clk,
   input  wire                       nreset,
   input  wire                       access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   output logic                      wait_out,
   output logic                      access_out,
   output emesh_pkg::emesh_packet_t  packet_out,
   input  wire                       wait_in
);

   // ####################
   // Internal wires
   // ####################
   emesh_pkg::emesh_packet_t ing_head;          // Ingress head to engine
   emesh_pkg::emesh_packet_t rsp_pkt;           // Engine to egress
   logic                     ing_push;
   logic                     ing_pop;
   logic                     ing_empty;
   logic                     ing_full;
   logic                     eg_push;
   logic                     eg_pop;
   logic                     eg_empty;
   logic                     eg_full;

   assign ing_push   = access_in && !ing_full;  // Accept when not waiting
   assign wait_out   = ing_full;
   assign access_out = !eg_empty;               // Valid response at head
   assign eg_pop     = !eg_empty && !wait_in;   // Delivered this edge

   // ####################
   // Datapath
   // ####################
   emesh_fifo #(.DEPTH(emesh_pkg::IN_DEPTH)) ingress_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .push      (ing_push),
      .push_data (packet_in),
      .pop       (ing_pop),
      .pop_data  (ing_head),
      .empty     (ing_empty),
      .full      (ing_full)
   );

   emesh_memory emem (
      .clk       (clk),
      .nreset    (nreset),
      .req       (ing_head),
      .req_empty (ing_empty),
      .rsp_full  (eg_full),
      .req_pop   (ing_pop),
      .rsp_push  (eg_push),
      .rsp       (rsp_pkt)
   );

   emesh_fifo #(.DEPTH(emesh_pkg::OUT_DEPTH)) egress_fifo (
      .clk       (clk),
      .nreset    (nreset),
      .push      (eg_push),
      .push_data (rsp_pkt),
      .pop       (eg_pop),
      .pop_data  (packet_out),
      .empty     (eg_empty),
      .full      (eg_full)
   );

   // Response held steady under back-pressure
   a_out_stable : assert property (
      @(posedge clk) disable iff (!nreset)
      (access_out && wait_in) |=> (access_out && $stable(packet_out))
   ) else $error("emesh_top response changed while waiting");

endmodule

`default_nettype wire
